// File: nd_pkg.sv
// ND console shared definitions
`default_nettype none

package nd_pkg;

  // Board clock and serial line
  localparam logic [31:0] SYS_CLK_HZ   = 32'd39_321_600;  // XTAL1 on the board
  localparam logic [31:0] BAUD_RATE    = 32'd9600;        // Fixed rate, no switch
  localparam logic [31:0] CLKS_PER_BIT = SYS_CLK_HZ / BAUD_RATE;  // 4096

  // Baud counter sizing
  localparam int BAUD_CNT_W = $clog2(CLKS_PER_BIT);
  localparam logic [BAUD_CNT_W-1:0] BIT_LAST = BAUD_CNT_W'(CLKS_PER_BIT - 1);
  localparam logic [BAUD_CNT_W-1:0] HALF_BIT = BAUD_CNT_W'(CLKS_PER_BIT / 2);

  // Octal value register
  localparam int VALUE_DIGITS = 6;
  localparam int VALUE_W      = 3 * VALUE_DIGITS;  // 18 bits
  localparam int DIGIT_CNT_W  = $clog2(VALUE_DIGITS + 1);
  // Slot after the last digit carries the CR
  localparam logic [DIGIT_CNT_W-1:0] REPORT_LAST = DIGIT_CNT_W'(VALUE_DIGITS);

  // Console characters
  localparam logic [7:0] CHR_RUN    = 8'h21;  // '!'
  localparam logic [7:0] CHR_STOP   = 8'h2E;  // '.'
  localparam logic [7:0] CHR_REPORT = 8'h2F;  // '/'
  localparam logic [7:0] CHR_CR     = 8'h0D;

  // Upper bits common to ASCII '0' to '7'
  localparam logic [4:0] OCTAL_CLASS = 5'b00110;

  // One received character from the UART
  typedef struct packed {
    logic       valid;      // Single-cycle strobe
    logic       frame_err;  // Stop bit sampled low
    logic [7:0] data;
  } rx_event_t;

  // Octal split of an ASCII byte
  typedef struct packed {
    logic [4:0] cls;
    logic [2:0] digit;
  } oct_split_t;

  // Same byte seen as a command code or as an octal digit
  typedef union packed {
    logic [7:0] raw;
    oct_split_t oct;
  } cmd_byte_u;

  // Board LED status, active high, bit 0 first
  typedef struct packed {
    logic tx_line;    // LED5
    logic rx_line;    // LED4
    logic tx_busy;    // LED3
    logic rx_busy;    // LED2
    logic frame_err;  // LED1
    logic run;        // LED0
  } led_status_t;

endpackage

`default_nettype wire

// File: baud_gen.sv
// UART bit and half-bit strobes
`timescale 1ns/10ps
`default_nettype none

module baud_gen
  import nd_pkg::*;
(
  input  wire  sysclk,
  input  wire  arst_n,
  input  wire  restart,    // From receiver on start edge
  output logic bit_tick,   // Free running, for transmitter
  output logic half_tick   // Mid-bit sample strobe
);

  logic [BAUD_CNT_W-1:0] bit_cnt;
  logic [BAUD_CNT_W-1:0] half_cnt;

  // Transmit bit counter, never realigned
  always_ff @(posedge sysclk or negedge arst_n) begin
    if (!arst_n) begin
      bit_cnt <= '0;
    end else if (bit_cnt == BIT_LAST) begin
      bit_cnt <= '0;
    end else begin
      bit_cnt <= bit_cnt + 1'b1;
    end
  end

  // Sample counter
  // Restart preloads half a bit so the first wrap lands mid start bit
  always_ff @(posedge sysclk or negedge arst_n) begin
    if (!arst_n) begin
      half_cnt <= '0;
    end else if (restart) begin
      half_cnt <= HALF_BIT;
    end else if (half_cnt == BIT_LAST) begin
      half_cnt <= '0;  // Then full-bit spacing
    end else begin
      half_cnt <= half_cnt + 1'b1;
    end
  end

  assign bit_tick  = (bit_cnt == BIT_LAST);
  assign half_tick = (half_cnt == BIT_LAST) && !restart;  // Restart wins

endmodule

`default_nettype wire

// File: uart_rx.sv
// UART receiver
`timescale 1ns/10ps
`default_nettype none

module uart_rx
  import nd_pkg::*;
(
  input  wire       sysclk,
  input  wire       arst_n,
  input  wire       rx,          // Async serial line
  input  wire       half_tick,   // Mid-bit strobe from baud_gen
  output logic      restart,     // Realign baud_gen sample counter
  output logic      rx_busy,
  output rx_event_t rx_event
);

  typedef enum logic [1:0] {
    S_IDLE,
    S_START,
    S_DATA,
    S_STOP
  } rx_state_t;

  rx_state_t  state;
  logic       rx_meta;   // Sync stage 1
  logic       rx_sync;   // Sync stage 2
  logic       rx_prev;   // For edge detect
  logic [2:0] bit_idx;
  logic [7:0] shift_reg;
  logic       start_edge;

  // Two-flop synchronizer plus delay, idle high
  always_ff @(posedge sysclk or negedge arst_n) begin
    if (!arst_n) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  assign start_edge = rx_prev && !rx_sync;  // Falling edge
  assign restart    = (state == S_IDLE) && start_edge;
  assign rx_busy    = (state != S_IDLE);

  // Frame sequencer
  always_ff @(posedge sysclk or negedge arst_n) begin
    if (!arst_n) begin
      state    <= S_IDLE;
      bit_idx  <= '0;
      rx_event <= '0;
    end else begin
      rx_event.valid <= 1'b0;  // Default, pulse only
      case (state)
        S_IDLE:  if (start_edge) state <= S_START;
        S_START: if (half_tick) begin
          // Line back high means a glitch
          state   <= rx_sync ? S_IDLE : S_DATA;
          bit_idx <= '0;
        end
        S_DATA:  if (half_tick) begin
          bit_idx <= bit_idx + 1'b1;
          if (bit_idx == 3'd7) state <= S_STOP;
        end
        S_STOP:  if (half_tick) begin
          rx_event.valid     <= 1'b1;
          rx_event.frame_err <= !rx_sync;  // Stop must be high
          rx_event.data      <= shift_reg;
          state              <= S_IDLE;
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // Data shifter, LSB arrives first
  always_ff @(posedge sysclk) begin
    if (state == S_DATA && half_tick) begin
      shift_reg <= {rx_sync, shift_reg[7:1]};
    end
  end

endmodule

`default_nettype wire

// File: uart_tx.sv
// UART transmitter
`timescale 1ns/10ps
`default_nettype none

module uart_tx (
  input  wire       sysclk,
  input  wire       arst_n,
  input  wire       bit_tick,   // Free-running bit strobe
  input  wire       tx_start,   // One cycle, only while idle
  input  wire [7:0] tx_data,
  output logic      tx_busy,
  output wire       tx          // Serial line
);

  logic [9:0] frame;    // Stop, data, start
  logic [3:0] bit_cnt;  // Ticks seen in this frame

  // Frame shifter
  // Idle frame is all ones so the line rests high
  always_ff @(posedge sysclk or negedge arst_n) begin
    if (!arst_n) begin
      frame   <= '1;
      bit_cnt <= '0;
      tx_busy <= 1'b0;
    end else if (tx_start && !tx_busy) begin
      frame   <= {1'b1, tx_data, 1'b0};  // Start bit out first
      bit_cnt <= '0;
      tx_busy <= 1'b1;                   // Visible the cycle after start
    end else if (tx_busy && bit_tick) begin
      // Start bit may be short since ticks never realign
      frame   <= {1'b1, frame[9:1]};     // Back-fill with idle level
      bit_cnt <= bit_cnt + 1'b1;
      if (bit_cnt == 4'd9) begin
        tx_busy <= 1'b0;                 // Stop bit done
      end
    end
  end

  assign tx = frame[0];  // Straight from a flop, no glitches

endmodule

`default_nettype wire

// File: opcom_console.sv
// OPCOM-style operator console
`timescale 1ns/10ps
`default_nettype none

module opcom_console
  import nd_pkg::*;
(
  input  wire            sysclk,
  input  wire            arst_n,
  input  wire rx_event_t rx_event,   // From receiver
  input  wire            tx_busy,
  output logic           tx_start,   // One cycle
  output logic [7:0]     tx_data,
  output logic           run,        // RUN flag
  output logic           frame_err   // Last character had a bad stop bit
);

  cmd_byte_u              cmd;        // Received byte, two views
  cmd_byte_u              rep_chr;    // Report digit being built
  logic                   busy_q;
  logic                   reporting;  // Report in progress
  logic [DIGIT_CNT_W-1:0] dig_cnt;
  logic [VALUE_W-1:0]     value;      // Octal value register
  logic [VALUE_W-1:0]     rep_sr;     // Report copy, MSB digit on top
  logic                   is_digit;
  logic                   accept;
  logic                   busy_fall;
  logic                   send_next;

  assign cmd.raw  = rx_event.data;
  assign is_digit = (cmd.oct.cls == OCTAL_CLASS);  // '0' to '7'

  // Good byte while console and transmitter are free
  // Anything else is dropped with no echo
  assign accept = rx_event.valid && !rx_event.frame_err && !reporting
                  && !tx_busy && !tx_start;

  assign busy_fall = busy_q && !tx_busy;
  assign send_next = reporting && busy_fall;  // Next report char

  // Top digit of the report copy as ASCII
  always_comb begin
    rep_chr.oct.cls   = OCTAL_CLASS;
    rep_chr.oct.digit = rep_sr[VALUE_W-1 -: 3];
  end

  // Control state
  always_ff @(posedge sysclk or negedge arst_n) begin
    if (!arst_n) begin
      busy_q    <= 1'b0;
      reporting <= 1'b0;
      dig_cnt   <= '0;
      tx_start  <= 1'b0;
      run       <= 1'b0;
      frame_err <= 1'b0;
      value     <= '0;
    end else begin
      busy_q   <= tx_busy;
      tx_start <= accept || send_next;  // One cycle after event or fall

      // Status tracks every character, set on bad, cleared on good
      if (rx_event.valid) frame_err <= rx_event.frame_err;

      if (accept) begin
        if (is_digit) begin
          value <= {value[VALUE_W-4:0], cmd.oct.digit};  // Top digit drops
        end else if (cmd.raw == CHR_RUN) begin
          run <= 1'b1;
        end else if (cmd.raw == CHR_STOP) begin
          run <= 1'b0;
        end else if (cmd.raw == CHR_REPORT) begin
          reporting <= 1'b1;  // Digits follow the echo
          dig_cnt   <= '0;
        end
        // Unknown characters are echo only
      end

      if (send_next) begin
        dig_cnt <= dig_cnt + 1'b1;
        if (dig_cnt == REPORT_LAST) reporting <= 1'b0;  // CR going out
      end
    end
  end

  // Output character and report copy
  always_ff @(posedge sysclk) begin
    if (accept) begin
      tx_data <= cmd.raw;  // Echo
      rep_sr  <= value;    // Stable across a report
    end else if (send_next) begin
      if (dig_cnt == REPORT_LAST) begin
        tx_data <= CHR_CR;
      end else begin
        tx_data <= rep_chr.raw;
        rep_sr  <= {rep_sr[VALUE_W-4:0], 3'b000};  // Next digit up
      end
    end
  end

endmodule

`default_nettype wire

// File: nd_fpga_top.sv
// ND console FPGA top level
`timescale 1ns/10ps
`default_nettype none

module nd_fpga_top
  import nd_pkg::*;
(
  input  wire       sysclk,   // 39.3216 MHz board clock
  input  wire       arst_n,   // Push button, active low
  input  wire       uart_rx,  // UART receive pin
  output wire       uart_tx,  // UART transmit pin
  output wire [5:0] led       // Board LEDs, active low
);

  logic        bit_tick;
  logic        half_tick;
  logic        restart;
  logic        rx_busy;
  logic        tx_busy;
  logic        tx_start;
  logic [7:0]  tx_data;
  logic        run;
  logic        frame_err;
  rx_event_t   rx_event;
  led_status_t status;

  baud_gen u_baud (
    .sysclk   (sysclk),
    .arst_n   (arst_n),
    .restart  (restart),
    .bit_tick (bit_tick),
    .half_tick(half_tick)
  );

  uart_rx u_rx (
    .sysclk   (sysclk),
    .arst_n   (arst_n),
    .rx       (uart_rx),
    .half_tick(half_tick),
    .restart  (restart),
    .rx_busy  (rx_busy),
    .rx_event (rx_event)
  );

  opcom_console u_console (
    .sysclk   (sysclk),
    .arst_n   (arst_n),
    .rx_event (rx_event),
    .tx_busy  (tx_busy),
    .tx_start (tx_start),
    .tx_data  (tx_data),
    .run      (run),
    .frame_err(frame_err)
  );

  uart_tx u_tx (
    .sysclk  (sysclk),
    .arst_n  (arst_n),
    .bit_tick(bit_tick),
    .tx_start(tx_start),
    .tx_data (tx_data),
    .tx_busy (tx_busy),
    .tx      (uart_tx)
  );

  // Status gather, line bits mirror the pins
  always_comb begin
    status.run       = run;
    status.frame_err = frame_err;
    status.rx_busy   = rx_busy;
    status.tx_busy   = tx_busy;
    status.rx_line   = uart_rx;
    status.tx_line   = uart_tx;
  end

  assign led = ~status;  // LEDs sink current

endmodule

`default_nettype wire

// File: tb_clock.sv
// Testbench clock and reset
`timescale 1ns/10ps
`default_nettype none

module tb_clock (
  output logic sysclk,
  output logic arst_n
);

  // 10 ns period
  initial begin
    sysclk = 1'b0;
    forever #5 sysclk = ~sysclk;
  end

  // Four cycles of reset, released on a falling edge
  initial begin
    arst_n = 1'b0;
    repeat (4) @(posedge sysclk);
    @(negedge sysclk);
    arst_n = 1'b1;
  end

endmodule

`default_nettype wire

// File: tb_nd_assertions.sv
// Console strobe assertions
`timescale 1ns/10ps
`default_nettype none

module tb_nd_assertions
  import nd_pkg::*;
(
  input wire            sysclk,
  input wire            arst_n,
  input wire rx_event_t rx_event,
  input wire            tx_busy,
  input wire            tx_start,
  input wire            run
);

  int assert_errors = 0;  // Failure count, read from the testbench top

  // Transmitter must be idle at each start
  start_idle_a: assert property (@(posedge sysclk) disable iff (!arst_n)
    tx_start |-> !tx_busy)
    else begin
      $error("tx_start issued while tx_busy high");
      assert_errors++;
    end

  start_pulse_a: assert property (@(posedge sysclk) disable iff (!arst_n)
    tx_start |=> !tx_start)
    else begin
      $error("tx_start longer than one cycle");
      assert_errors++;
    end

  valid_pulse_a: assert property (@(posedge sysclk) disable iff (!arst_n)
    rx_event.valid |=> !rx_event.valid)
    else begin
      $error("rx_event.valid longer than one cycle");
      assert_errors++;
    end

  // RUN comes out of reset cleared
  run_reset_a: assert property (@(posedge sysclk) $rose(arst_n) |-> !run)
    else begin
      $error("run high in first cycle after reset");
      assert_errors++;
    end

endmodule

bind opcom_console tb_nd_assertions u_assert (
  .sysclk  (sysclk),
  .arst_n  (arst_n),
  .rx_event(rx_event),
  .tx_busy (tx_busy),
  .tx_start(tx_start),
  .run     (run)
);

`default_nettype wire

// File: tb_nd_top.sv
// ND console directed testbench
`timescale 1ns/10ps
`default_nettype none

module tb_nd_top
  import nd_pkg::*;
();

  localparam int BIT_CYC     = int'(CLKS_PER_BIT);
  localparam int MAX_CHARS   = 60;
  localparam int TIMEOUT_CYC = (MAX_CHARS * 10 + 200) * BIT_CYC;  // Chars plus margin
  localparam int RX_WAIT     = 12 * BIT_CYC;   // Longest gap before a reply starts
  localparam int SEED        = 32'h5febc6b0;

  wire        sysclk;
  wire        arst_n;
  logic       uart_rx;
  wire        uart_tx;
  wire  [5:0] led;
  int         cyc;        // Cycles since reset release
  int         pass_cnt;
  int         fail_cnt;
  int         test_errs;
  string      cur_test;

  tb_clock u_clk (.sysclk(sysclk), .arst_n(arst_n));

  nd_fpga_top DUT (
    .sysclk (sysclk),
    .arst_n (arst_n),
    .uart_rx(uart_rx),
    .uart_tx(uart_tx),
    .led    (led)
  );

  // Same phase as the free-running bit strobe
  always @(posedge sysclk or negedge arst_n) begin
    if (!arst_n) cyc <= 0;
    else cyc <= cyc + 1;
  end

  always @(posedge sysclk) begin
    if (cyc >= TIMEOUT_CYC) begin
      $display("Timeout after %0d cycles, tests did not finish", cyc);
      $display("Simulation failed");
      $finish;
    end
  end

  // One UART frame, LSB first, optional bad stop bit
  task automatic send_char(input logic [7:0] data, input bit bad_stop);
    logic [9:0] frame;
    frame = {~bad_stop, data, 1'b0};
    for (int i = 0; i < 10; i++) begin
      @(posedge sysclk);
      uart_rx <= frame[i];
      repeat (BIT_CYC - 1) @(posedge sysclk);
    end
    @(posedge sysclk);
    uart_rx <= 1'b1;  // Back to idle
  endtask

  // Start bit may be short, data bits sit on the bit-tick grid
  task automatic recv_char(output logic [7:0] data, output bit ok);
    logic [8:0] bits;  // Data then stop
    int         waited;
    waited = 0;
    ok     = 1'b0;
    data   = '0;
    do begin
      @(negedge sysclk);
      waited++;
    end while (uart_tx !== 1'b0 && waited < RX_WAIT);
    if (uart_tx === 1'b0) begin
      while ((cyc % BIT_CYC) != BIT_CYC - 1) @(negedge sysclk);
      @(posedge sysclk);                        // Data bit 0 goes out
      repeat (BIT_CYC / 2) @(negedge sysclk);   // Mid bit
      for (int i = 0; i < 9; i++) begin
        bits[i] = uart_tx;
        if (i < 8) repeat (BIT_CYC) @(negedge sysclk);
      end
      data = bits[7:0];
      ok   = (bits[8] === 1'b1);
    end
  endtask

  task automatic expect_char(input string what, input logic [7:0] exp);
    logic [7:0] got;
    bit         ok;
    recv_char(got, ok);
    if (!ok) begin
      $display("%s: no valid %s frame arrived on uart_tx", cur_test, what);
      test_errs++;
    end else if (got !== exp) begin
      $display("FAIL %s %s: expected 8'h%02h actual 8'h%02h", cur_test, what, exp, got);
      test_errs++;
    end
  endtask

  // Send while listening for the echo
  task automatic send_and_check(input logic [7:0] c);
    fork
      send_char(c, 1'b0);
      expect_char("echo", c);
    join
  endtask

  task automatic watch_silence(input int cycles, output bit quiet);
    quiet = 1'b1;
    repeat (cycles) begin
      @(negedge sysclk);
      if (uart_tx !== 1'b1) quiet = 1'b0;
    end
  endtask

  task automatic check_led(input string what, input int idx, input logic exp);
    if (led[idx] !== exp) begin
      $display("FAIL %s %s: expected led[%0d]=%b actual %b", cur_test, what, idx, exp,
               led[idx]);
      test_errs++;
    end
  endtask

  // Printable, neither a command nor an octal digit
  function automatic logic [7:0] plain_char();
    logic [7:0] c;
    do begin
      c = 8'(8'h20 + ($urandom % 95));
    end while (c == CHR_RUN || c == CHR_STOP || c == CHR_REPORT ||
               (c >= 8'h30 && c <= 8'h37));
    return c;
  endfunction

  task automatic begin_test(input string name);
    cur_test  = name;
    test_errs = 0;
  endtask

  task automatic end_test();
    if (test_errs == 0) begin
      pass_cnt++;
      $display("%s: ok", cur_test);
    end else begin
      fail_cnt++;
      $display("%s: %0d error(s)", cur_test, test_errs);
    end
  endtask

  task automatic check_reset_leds();
    begin_test("reset_leds");
    // Only the idle-high line mirrors are lit
    if (led !== 6'b001111) begin
      $display("FAIL %s: expected 6'b001111 actual 6'b%06b", cur_test, led);
      test_errs++;
    end
    end_test();
  endtask

  task automatic echo_random_bytes();
    begin_test("echo_random");
    repeat (10) send_and_check(plain_char());
    end_test();
  endtask

  task automatic run_stop_flag();
    begin_test("run_stop");
    send_and_check(CHR_RUN);
    check_led("run set", 0, 1'b0);      // LED0 on
    send_and_check(CHR_STOP);
    check_led("run cleared", 0, 1'b1);
    end_test();
  endtask

  task automatic octal_report();
    int n;
    int digits[$];
    begin_test("octal_report");
    n = 6 + int'($urandom % 4);  // Some runs push old digits out
    for (int i = 0; i < n; i++) begin
      digits.push_back(int'($urandom % 8));
      send_and_check(8'h30 + 8'(digits[i]));
    end
    send_and_check(CHR_REPORT);
    // Last six digits, oldest first
    for (int k = n - VALUE_DIGITS; k < n; k++) begin
      expect_char("report digit", 8'h30 + 8'(digits[k]));
    end
    expect_char("report end", CHR_CR);
    end_test();
  endtask

  task automatic framing_error();
    bit quiet;
    begin_test("framing_error");
    fork
      send_char(plain_char(), 1'b1);
      watch_silence(RX_WAIT, quiet);
    join
    if (!quiet) begin
      $display("%s: character with a low stop bit was echoed", cur_test);
      test_errs++;
    end
    check_led("error lit", 1, 1'b0);
    send_and_check(plain_char());
    check_led("error cleared", 1, 1'b1);
    end_test();
  endtask

  initial begin
    void'($urandom(SEED));
    uart_rx   = 1'b1;
    pass_cnt  = 0;
    fail_cnt  = 0;
    test_errs = 0;
    wait (arst_n === 1'b1);
    repeat (4) @(posedge sysclk);
    check_reset_leds();
    echo_random_bytes();
    run_stop_flag();
    octal_report();
    framing_error();
    if (DUT.u_console.u_assert.assert_errors != 0) fail_cnt++;  // Bound checks
    $display("Tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tb.f
nd_pkg.sv
baud_gen.sv
uart_rx.sv
uart_tx.sv
opcom_console.sv
nd_fpga_top.sv
tb_clock.sv
tb_nd_assertions.sv
tb_nd_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the ND console testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_nd_top \
  -f tb.f --Mdir "$BUILD_DIR" -o sim_nd
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

"./$BUILD_DIR/sim_nd" +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
  echo "Simulator exited with status $status"
  exit 1
fi

if grep -qx "Simulation passed" "$LOG"; then
  exit 0
fi
exit 1
